// ==== Bender.yml ====
package:
  name: tail_light

dependencies: {}

sources:
  # Controller RTL, package first
  - files:
      - design/tail_light_pkg.sv
      - design/tick_divider.sv
      - design/sweep_sequencer.sv
      - design/lamp_cell.sv
      - design/panel_register.sv
      - design/tail_light_top.sv

  # Bound assertions and testbench
  - target: simulation
    files:
      - dv/tail_light_sva.sv
      - dv/tail_light_tb.sv

// ==== design/lamp_cell.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lamp cell
// Lamp and bar fill for one lamp position
// on one side, from the current sweep step
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module lamp_cell #(
    parameter tail_light_pkg::mode_e side     = tail_light_pkg::mode_right,
    parameter int                    position = 0   // Lamp index on its side
) (
    input  tail_light_pkg::sweep_t sweep,
    output tail_light_pkg::lamp_t  lamp
);

    always_comb begin
        lamp.lit   = 1'b0;
        lamp.fill  = '0;
        if (sweep.mode == tail_light_pkg::mode_hazard) begin
            lamp.lit  = 1'b1;                  // Everything on
            lamp.fill = '1;
        end else if (sweep.mode == side) begin
            // Segment k is on once the step reaches it, so the fill is a
            // thermometer that saturates when the next lamp takes over
            for (int k = 0; k < tail_light_pkg::segs_per_lamp; k++) begin
                lamp.fill[k] = (int'(sweep.step) >= position * tail_light_pkg::segs_per_lamp + k);
            end
            lamp.lit = (int'(sweep.step) >= position * tail_light_pkg::segs_per_lamp);
        end
    end

endmodule

// ==== design/panel_register.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Panel register
// Registers the lamp cells onto the pins,
// segments active low, plus hazard flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module panel_register (
    input  logic                  clock,
    input  logic                  rst_n,
    input  tail_light_pkg::lamp_t cells [tail_light_pkg::lamp_count],
    input  tail_light_pkg::mode_e mode,
    output logic [tail_light_pkg::lamps_per_side-1:0]                 right_lamps,
    output logic [tail_light_pkg::lamps_per_side-1:0]                 left_lamps,
    output tail_light_pkg::seg_fill_t [tail_light_pkg::lamps_per_side-1:0] right_segments,
    output tail_light_pkg::seg_fill_t [tail_light_pkg::lamps_per_side-1:0] left_segments,
    output logic                                                      all_lights
);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            right_lamps    <= '0;
            left_lamps     <= '0;
            right_segments <= '1;              // Dark displays
            left_segments  <= '1;
            all_lights     <= 1'b0;
        end else begin
            for (int i = 0; i < tail_light_pkg::lamps_per_side; i++) begin
                // Cells 0 to 2 are the right side
                right_lamps[i]    <= cells[i].lit;
                right_segments[i] <= ~cells[i].fill;
                // Left side follows in the cell array
                left_lamps[i]     <= cells[tail_light_pkg::lamps_per_side + i].lit;
                left_segments[i]  <= ~cells[tail_light_pkg::lamps_per_side + i].fill;
            end
            all_lights <= (mode == tail_light_pkg::mode_hazard);
        end
    end

endmodule

// ==== design/sweep_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sweep sequencer
// Mode FSM plus step counter. Buttons are
// active low and only looked at on a tick;
// hazard overrides a running sweep
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module sweep_sequencer (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   tick,
    input  logic                   right_button,
    input  logic                   left_button,
    input  logic                   hazard_button,
    output tail_light_pkg::sweep_t sweep
);

    tail_light_pkg::mode_e mode_q;
    tail_light_pkg::mode_e mode_d;
    tail_light_pkg::step_t step_q;
    tail_light_pkg::step_t step_d;
    logic                  last_step;

    assign last_step = (step_q == tail_light_pkg::step_t'(tail_light_pkg::sweep_steps - 1));

    always_comb begin
        mode_d = mode_q;
        step_d = step_q;
        if (tick) begin
            case (mode_q)
                tail_light_pkg::mode_idle: begin
                    step_d = '0;
                    // Right beats left, left beats hazard
                    if (!right_button) begin
                        mode_d = tail_light_pkg::mode_right;
                    end else if (!left_button) begin
                        mode_d = tail_light_pkg::mode_left;
                    end else if (!hazard_button) begin
                        mode_d = tail_light_pkg::mode_hazard;
                    end
                end
                tail_light_pkg::mode_right,
                tail_light_pkg::mode_left: begin
                    if (!hazard_button) begin
                        mode_d = tail_light_pkg::mode_hazard;   // Cancel the sweep
                        step_d = '0;
                    end else if (last_step) begin
                        mode_d = tail_light_pkg::mode_idle;     // Sweep done, go dark
                        step_d = '0;
                    end else begin
                        step_d = step_q + 1'b1;
                    end
                end
                tail_light_pkg::mode_hazard: begin
                    // Single lit tick, a held button gives the blink
                    mode_d = tail_light_pkg::mode_idle;
                    step_d = '0;
                end
                default: begin
                    mode_d = tail_light_pkg::mode_idle;
                    step_d = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mode_q <= tail_light_pkg::mode_idle;
            step_q <= '0;
        end else begin
            mode_q <= mode_d;
            step_q <= step_d;
        end
    end

    assign sweep.mode = mode_q;
    assign sweep.step = step_q;

endmodule

// ==== design/tail_light_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tail light controller definitions
// Lamp and segment counts, the tick rate
// and the types passed from the sequencer
// through the lamp cells to the panel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package tail_light_pkg;

    localparam int segs_per_lamp    = 6;                    // Bar display per lamp
    localparam int lamps_per_side   = 3;
    localparam int lamp_count       = 2 * lamps_per_side;   // Right side first, then left
    localparam int sweep_steps      = lamps_per_side * segs_per_lamp;
    localparam int tick_div_default = 4200000;              // Board clock cycles per step

    // Position within one sweep, 0 to sweep_steps - 1
    typedef logic [$clog2(sweep_steps)-1:0] step_t;

    // Bit k lit means segment k is on, active high inside the design
    typedef logic [segs_per_lamp-1:0] seg_fill_t;

    typedef enum logic [1:0] {
        mode_idle   = 2'd0,
        mode_right  = 2'd1,
        mode_left   = 2'd2,
        mode_hazard = 2'd3
    } mode_e;

    // Sequencer broadcast to every lamp cell
    typedef struct packed {
        mode_e mode;
        step_t step;
    } sweep_t;

    // One lamp and its bar display
    typedef struct packed {
        logic      lit;
        seg_fill_t fill;
    } lamp_t;

endpackage

// ==== design/tail_light_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tail light controller top level
// Sequential turn signal and hazard lights
// with three lamps and bar displays a side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tail_light_top #(
    parameter int tick_div = tail_light_pkg::tick_div_default
) (
    input  logic clock,
    input  logic rst_n,
    input  logic right_button,                  // Active low
    input  logic left_button,                   // Active low
    input  logic hazard_button,                 // Active low
    output logic [tail_light_pkg::lamps_per_side-1:0]                 right_lamps,
    output logic [tail_light_pkg::lamps_per_side-1:0]                 left_lamps,
    output tail_light_pkg::seg_fill_t [tail_light_pkg::lamps_per_side-1:0] right_segments,
    output tail_light_pkg::seg_fill_t [tail_light_pkg::lamps_per_side-1:0] left_segments,
    output logic                                                      all_lights
);

    logic                   tick;
    tail_light_pkg::sweep_t sweep;
    tail_light_pkg::lamp_t  cells [tail_light_pkg::lamp_count];

    tick_divider #(
        .tick_div (tick_div)
    ) u_tick_divider (
        .clock (clock),
        .rst_n (rst_n),
        .tick  (tick)
    );

    sweep_sequencer u_sweep_sequencer (
        .clock         (clock),
        .rst_n         (rst_n),
        .tick          (tick),
        .right_button  (right_button),
        .left_button   (left_button),
        .hazard_button (hazard_button),
        .sweep         (sweep)
    );

    // First half of the cells on the right, second half on the left
    for (genvar i = 0; i < tail_light_pkg::lamp_count; i++) begin : g_cell
        lamp_cell #(
            .side     (tail_light_pkg::mode_e'((i < tail_light_pkg::lamps_per_side) ?
                       tail_light_pkg::mode_right : tail_light_pkg::mode_left)),
            .position (i % tail_light_pkg::lamps_per_side)
        ) u_lamp_cell (
            .sweep (sweep),
            .lamp  (cells[i])
        );
    end

    panel_register u_panel_register (
        .clock          (clock),
        .rst_n          (rst_n),
        .cells          (cells),
        .mode           (sweep.mode),
        .right_lamps    (right_lamps),
        .left_lamps     (left_lamps),
        .right_segments (right_segments),
        .left_segments  (left_segments),
        .all_lights     (all_lights)
    );

endmodule

// ==== design/tick_divider.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tick divider
// Counts tick_div clock cycles and gives a
// one-cycle step strobe on terminal count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tick_divider #(
    parameter int tick_div = tail_light_pkg::tick_div_default
) (
    input  logic clock,
    input  logic rst_n,
    output logic tick
);

    // Counter just wide enough for 0 to tick_div - 1
    typedef logic [$clog2((tick_div > 1) ? tick_div : 2)-1:0] count_t;

    count_t count_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (tick) begin
            count_q <= '0;                        // Wrap on terminal count
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    // Decoded from the register so the strobe is clean and one cycle wide
    assign tick = (count_q == count_t'(tick_div - 1));

endmodule

// ==== dv/tail_light_sva.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tail light output assertions
// Side exclusion, full hazard panel and
// monotonic bar fill on the top level pins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tail_light_sva (
    input logic                                                      clock,
    input logic                                                      rst_n,
    input logic [tail_light_pkg::lamps_per_side-1:0]                 right_lamps,
    input logic [tail_light_pkg::lamps_per_side-1:0]                 left_lamps,
    input tail_light_pkg::seg_fill_t [tail_light_pkg::lamps_per_side-1:0] right_segments,
    input tail_light_pkg::seg_fill_t [tail_light_pkg::lamps_per_side-1:0] left_segments,
    input logic                                                      all_lights
);

    logic [tail_light_pkg::sweep_steps-1:0] right_lit;
    logic [tail_light_pkg::sweep_steps-1:0] left_lit;
    int                                     failure_count = 0;

    assign right_lit = ~right_segments;      // Active high copies
    assign left_lit  = ~left_segments;

    sides_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
        (right_lit != '0 && left_lit != '0) |-> all_lights)
        else begin
            failure_count++;
            $error("Both sides lit while all_lights is low");
        end

    full_on_hazard: assert property (@(posedge clock) disable iff (!rst_n)
        all_lights |-> (right_lamps == '1 && left_lamps == '1 &&
                        right_lit == '1 && left_lit == '1))
        else begin
            failure_count++;
            $error("all_lights set without the full panel");
        end

    // A bar may grow or go fully dark at the end of a sweep
    right_fills_only: assert property (@(posedge clock) disable iff (!rst_n)
        (!all_lights && !$past(all_lights) && right_lit != $past(right_lit)) |->
        ((right_lit & $past(right_lit)) == $past(right_lit) || right_lit == '0))
        else begin
            failure_count++;
            $error("Right segment bar lost segments during a sweep");
        end

    left_fills_only: assert property (@(posedge clock) disable iff (!rst_n)
        (!all_lights && !$past(all_lights) && left_lit != $past(left_lit)) |->
        ((left_lit & $past(left_lit)) == $past(left_lit) || left_lit == '0))
        else begin
            failure_count++;
            $error("Left segment bar lost segments during a sweep");
        end

endmodule

bind tail_light_top tail_light_sva sva0 (
    .clock          (clock),
    .rst_n          (rst_n),
    .right_lamps    (right_lamps),
    .left_lamps     (left_lamps),
    .right_segments (right_segments),
    .left_segments  (left_segments),
    .all_lights     (all_lights)
);

// ==== dv/tail_light_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tail light controller testbench
// Directed tests for reset, both sweeps,
// hazard blink, hazard override and the
// button priority, with a fast tick
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tail_light_tb;

    localparam int tick_div_tb    = 4;       // One step every 4 clocks
    localparam int change_timeout = 200;     // Cycles allowed per output change

    // Snapshot of the panel pins, segments turned active high
    typedef struct packed {
        logic [tail_light_pkg::lamps_per_side-1:0] right_lamps;
        logic [tail_light_pkg::lamps_per_side-1:0] left_lamps;
        logic [tail_light_pkg::sweep_steps-1:0]    right_fill;
        logic [tail_light_pkg::sweep_steps-1:0]    left_fill;
        logic                                      all_lights;
    } panel_t;

    logic clock;
    logic rst_n;
    logic right_button;
    logic left_button;
    logic hazard_button;
    logic [tail_light_pkg::lamps_per_side-1:0]                      right_lamps;
    logic [tail_light_pkg::lamps_per_side-1:0]                      left_lamps;
    tail_light_pkg::seg_fill_t [tail_light_pkg::lamps_per_side-1:0] right_segments;
    tail_light_pkg::seg_fill_t [tail_light_pkg::lamps_per_side-1:0] left_segments;
    logic                                                           all_lights;

    int          error_count;
    int          test_count;
    int          assertion_failures;
    panel_t      last_panel;                 // Panel as of the last seen change

    tail_light_top #(
        .tick_div (tick_div_tb)
    ) dut0 (
        .clock          (clock),
        .rst_n          (rst_n),
        .right_button   (right_button),
        .left_button    (left_button),
        .hazard_button  (hazard_button),
        .right_lamps    (right_lamps),
        .left_lamps     (left_lamps),
        .right_segments (right_segments),
        .left_segments  (left_segments),
        .all_lights     (all_lights)
    );

    always #10 clock = ~clock;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    function automatic panel_t sample_panel();
        panel_t p;
        p.right_lamps = right_lamps;
        p.left_lamps  = left_lamps;
        p.right_fill  = ~right_segments;     // Pins are active low
        p.left_fill   = ~left_segments;
        p.all_lights  = all_lights;
        return p;
    endfunction

    function automatic panel_t dark_panel();
        return '0;
    endfunction

    function automatic panel_t full_panel();
        return '1;
    endfunction

    // Lowest count segments lit, lamp i on once its first segment is reached
    function automatic panel_t sweep_panel(input bit left_side, input int count);
        panel_t                                    p;
        logic [tail_light_pkg::lamps_per_side-1:0] lamps;
        logic [tail_light_pkg::sweep_steps-1:0]    fill;
        p     = '0;
        lamps = '0;
        fill  = '0;
        for (int k = 0; k < count; k++) begin
            fill[k] = 1'b1;
        end
        for (int i = 0; i < tail_light_pkg::lamps_per_side; i++) begin
            lamps[i] = (count > i * tail_light_pkg::segs_per_lamp);
        end
        if (left_side) begin
            p.left_lamps = lamps;
            p.left_fill  = fill;
        end else begin
            p.right_lamps = lamps;
            p.right_fill  = fill;
        end
        return p;
    endfunction

    task automatic check_panel(input panel_t actual, input panel_t expected, input string what);
        check_value(actual.right_lamps, expected.right_lamps, {what, ", right lamps"});
        check_value(actual.left_lamps, expected.left_lamps, {what, ", left lamps"});
        check_value(actual.right_fill, expected.right_fill, {what, ", right segments lit"});
        check_value(actual.left_fill, expected.left_fill, {what, ", left segments lit"});
        check_value(actual.all_lights, expected.all_lights, {what, ", all_lights"});
    endtask

    task automatic drive_buttons(input logic right_level, input logic left_level,
                                 input logic hazard_level);
        @(posedge clock);
        #2;
        right_button  = right_level;
        left_button   = left_level;
        hazard_button = hazard_level;
    endtask

    task automatic abort_on_timeout(input string where);
        $display("Timeout: the outputs did not change within %0d cycles during %s",
                 change_timeout, where);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic wait_change(input string where);
        int     cycles;
        panel_t now;
        cycles = 0;
        now    = sample_panel();
        while (now == last_panel && cycles < change_timeout) begin
            @(negedge clock);
            now = sample_panel();
            cycles++;
        end
        if (now == last_panel) begin
            abort_on_timeout(where);
        end else begin
            last_panel = now;
        end
    endtask

    // Rest of a sweep from step first_count, then the dark panel
    task automatic follow_sweep(input bit left_side, input int first_count, input string name);
        string what;
        for (int count = first_count; count <= tail_light_pkg::sweep_steps; count++) begin
            what = $sformatf("%s, %0d segments", name, count);
            wait_change(what);
            check_panel(last_panel, sweep_panel(left_side, count), what);
            check_value($countones(left_side ? last_panel.left_fill : last_panel.right_fill),
                        count, {what, ", lit count"});
        end
        wait_change({name, ", end of sweep"});
        check_panel(last_panel, dark_panel(), {name, ", end of sweep"});
    endtask

    task automatic hold_check_dark(input string name);
        repeat (3 * tick_div_tb) @(negedge clock);
        check_panel(sample_panel(), dark_panel(), {name, ", idle afterwards"});
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        $display("Test %0d, %s: %s", test_count, name,
                 (error_count == errors_before) ? "ok" : "mismatches found");
    endtask

    task automatic test_reset_values();
        int errors_before;
        errors_before = error_count;
        rst_n = 1'b0;
        repeat (3) @(posedge clock);
        #2;
        check_panel(sample_panel(), dark_panel(), "during reset");
        check_value(right_segments, {tail_light_pkg::sweep_steps{1'b1}}, "right segment pins");
        check_value(left_segments, {tail_light_pkg::sweep_steps{1'b1}}, "left segment pins");
        rst_n = 1'b1;
        @(negedge clock);
        check_panel(sample_panel(), dark_panel(), "after reset");
        last_panel = sample_panel();
        finish_test("reset values", errors_before);
    endtask

    task automatic test_sweep(input bit left_side, input string name);
        int errors_before;
        errors_before = error_count;
        last_panel    = sample_panel();
        drive_buttons(left_side, !left_side, 1'b1);   // Brief press on one side
        wait_change(name);
        drive_buttons(1'b1, 1'b1, 1'b1);
        check_panel(last_panel, sweep_panel(left_side, 1), {name, ", first step"});
        follow_sweep(left_side, 2, name);
        finish_test(name, errors_before);
    endtask

    task automatic test_hazard_blink();
        int errors_before;
        errors_before = error_count;
        last_panel    = sample_panel();
        drive_buttons(1'b1, 1'b1, 1'b0);
        for (int i = 0; i < 4; i++) begin
            wait_change("hazard blink");
            check_panel(last_panel, (i % 2 == 0) ? full_panel() : dark_panel(),
                        $sformatf("hazard blink, change %0d", i + 1));
        end
        drive_buttons(1'b1, 1'b1, 1'b1);
        hold_check_dark("hazard blink");
        finish_test("hazard blink", errors_before);
    endtask

    task automatic test_hazard_override();
        int errors_before;
        int changes;
        errors_before = error_count;
        changes       = $urandom_range(15, 1);        // Sweep steps seen before hazard
        last_panel    = sample_panel();
        drive_buttons(1'b0, 1'b1, 1'b1);
        wait_change("override sweep start");
        drive_buttons(1'b1, 1'b1, 1'b1);
        check_panel(last_panel, sweep_panel(1'b0, 1), "override sweep start");
        for (int count = 2; count <= changes; count++) begin
            wait_change("override sweep");
            check_panel(last_panel, sweep_panel(1'b0, count),
                        $sformatf("override sweep, %0d segments", count));
        end
        drive_buttons(1'b1, 1'b1, 1'b0);
        wait_change("hazard override");
        check_panel(last_panel, full_panel(), "hazard override");
        drive_buttons(1'b1, 1'b1, 1'b1);
        wait_change("hazard release");
        check_panel(last_panel, dark_panel(), "hazard release");
        hold_check_dark("hazard override");
        finish_test($sformatf("hazard override after %0d steps", changes), errors_before);
    endtask

    task automatic test_priority();
        int errors_before;
        errors_before = error_count;
        last_panel    = sample_panel();
        drive_buttons(1'b0, 1'b0, 1'b1);              // Right and left together
        wait_change("right over left");
        drive_buttons(1'b1, 1'b1, 1'b1);
        check_panel(last_panel, sweep_panel(1'b0, 1), "right over left");
        follow_sweep(1'b0, 2, "right over left");
        drive_buttons(1'b1, 1'b0, 1'b0);              // Left and hazard together
        wait_change("left over hazard");
        drive_buttons(1'b1, 1'b1, 1'b1);
        check_panel(last_panel, sweep_panel(1'b1, 1), "left over hazard");
        follow_sweep(1'b1, 2, "left over hazard");
        finish_test("priority", errors_before);
    endtask

    initial begin
        clock         = 1'b0;
        rst_n         = 1'b0;
        right_button  = 1'b1;                        // Released
        left_button   = 1'b1;
        hazard_button = 1'b1;
        error_count   = 0;
        test_count    = 0;
        void'($urandom(32'h131f6b40));
        test_reset_values();
        test_sweep(1'b0, "right sweep");
        test_sweep(1'b1, "left sweep");
        test_hazard_blink();
        test_hazard_override();
        test_priority();
        assertion_failures = dut0.sva0.failure_count;
        $display("%0d tests run, %0d check errors, %0d assertion failures",
                 test_count, error_count, assertion_failures);
        if (error_count == 0 && assertion_failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/tail_light_pkg.sv
design/tick_divider.sv
design/sweep_sequencer.sv
design/lamp_cell.sv
design/panel_register.sv
design/tail_light_top.sv
dv/tail_light_sva.sv
dv/tail_light_tb.sv
